// ==== rtl/bt_pkg.sv ====
package bt_pkg;

  //////////////////////////////
  // timing constants
  //////////////////////////////

  // clk_6M cycles per 1 us bit strobe
  localparam int CLKS_PER_US = 6;

  // clk_6M cycles per native clock tick, 312.5 us
  localparam int CLKS_PER_HALF_SLOT = 1875;

  // prescaler and half-slot counter widths
  localparam int US_CNT_W = 3;
  localparam int HS_CNT_W = 11;

  //////////////////////////////
  // widths
  //////////////////////////////

  localparam int BT_CLK_W  = 28;
  localparam int SLOT_HI_W = BT_CLK_W - 2;
  localparam int SYNC_W    = 64;
  localparam int SCORE_W   = 7;
  localparam int THRESH_W  = 6;

  // access code select
  localparam logic [1:0] ACC_CAC  = 2'd0;
  localparam logic [1:0] ACC_DAC  = 2'd1;
  localparam logic [1:0] ACC_GIAC = 2'd2;
  localparam logic [1:0] ACC_DIAC = 2'd3;

  //////////////////////////////
  // clock word
  //////////////////////////////

  // whole count, or slot number plus half-slot phase
  typedef union packed {
    logic [BT_CLK_W-1:0] raw;
    struct packed {
      logic [SLOT_HI_W-1:0] slot_hi;
      logic [1:0]           phase;
    } parts;
  } bt_clk_u;

endpackage

// ==== rtl/bt_timebase.sv ====
`timescale 1ns/1ps

module bt_timebase
  import bt_pkg::*;
(
  input  logic                clk_6M,
  input  logic                rstz,
  input  logic                is_master,
  input  logic [BT_CLK_W-1:0] slave_offset,
  output logic                p_1us,
  output logic                slot_p,
  output bt_clk_u             clkn,
  output bt_clk_u             clk
);

  logic [US_CNT_W-1:0] us_cnt;
  logic                us_wrap;
  logic [HS_CNT_W-1:0] hs_cnt;
  logic                hs_wrap;
  bt_clk_u             clk_nxt;

  //////////////////////////////
  // 1 us strobe
  //////////////////////////////

  assign us_wrap = (us_cnt == US_CNT_W'(CLKS_PER_US - 1));

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      us_cnt <= '0;
      p_1us  <= 1'b0;
    end
    else
    begin
      // strobe goes high as the prescaler wraps
      p_1us <= us_wrap;
      if (us_wrap)
        us_cnt <= '0;
      else
        us_cnt <= us_cnt + 1'b1;
    end
  end

  //////////////////////////////
  // native clock
  //////////////////////////////

  assign hs_wrap = (hs_cnt == HS_CNT_W'(CLKS_PER_HALF_SLOT - 1));

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      hs_cnt   <= '0;
      clkn.raw <= '0;
    end
    else
    begin
      if (hs_wrap)
      begin
        hs_cnt   <= '0;
        clkn.raw <= clkn.raw + 1'b1;
      end
      else
        hs_cnt <= hs_cnt + 1'b1;
    end
  end

  //////////////////////////////
  // piconet clock
  //////////////////////////////

  // slave runs on native clock plus offset, wraps mod 2^28
  always_comb
  begin
    if (is_master)
      clk_nxt.raw = clkn.raw;
    else
      clk_nxt.raw = clkn.raw + slave_offset;
  end

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      clk.raw <= '0;
      slot_p  <= 1'b0;
    end
    else
    begin
      clk    <= clk_nxt;
      // slot boundary when phase rolls over to zero
      slot_p <= (clk_nxt.parts.phase == 2'b00) && (clk.parts.phase != 2'b00);
    end
  end

endmodule

// ==== rtl/bt_rx_window.sv ====
`timescale 1ns/1ps

module bt_rx_window
  import bt_pkg::*;
(
  input  logic              clk_6M,
  input  logic              rstz,
  input  logic              rxbit,
  input  logic              p_1us,
  output logic [SYNC_W-1:0] window,
  output logic              bit_p
);

  logic [1:0] rxbit_as;

  //////////////////////////////
  // resync
  //////////////////////////////

  // two flops, rxbit comes from the radio domain
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      rxbit_as <= 2'b00;
    else
      rxbit_as <= {rxbit_as[0], rxbit};
  end

  //////////////////////////////
  // sliding window
  //////////////////////////////

  // newest sample enters at bit 0
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      window <= '0;
    else if (p_1us)
      window <= {window[SYNC_W-2:0], rxbit_as[1]};
  end

  // new window valid in the cycle after the shift
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      bit_p <= 1'b0;
    else
      bit_p <= p_1us;
  end

endmodule

// ==== rtl/bt_sync_correlator.sv ====
`timescale 1ns/1ps

module bt_sync_correlator
  import bt_pkg::*;
(
  input  logic                 clk_6M,
  input  logic                 rstz,
  input  logic                 bit_p,
  input  logic [SYNC_W-1:0]    window,
  input  logic [SYNC_W-1:0]    syncword_cac,
  input  logic [SYNC_W-1:0]    syncword_dac,
  input  logic [SYNC_W-1:0]    syncword_giac,
  input  logic [SYNC_W-1:0]    syncword_diac,
  input  logic [1:0]           access_sel,
  input  logic [THRESH_W-1:0]  correthreshold,
  input  bt_clk_u              clk,
  output logic                 corre_sync_p,
  output logic [SLOT_HI_W-1:0] sync_clk_hi
);

  logic [SYNC_W-1:0]  sync_sel;
  logic [SYNC_W-1:0]  agree;
  logic [SCORE_W-1:0] score;
  logic               score_vld;
  logic               hit;

  // number of set bits in a window-wide word
  function automatic logic [SCORE_W-1:0] count_ones(input logic [SYNC_W-1:0] v);
    logic [SCORE_W-1:0] n;
    n = '0;
    for (int i = 0; i < SYNC_W; i++)
      n = n + SCORE_W'(v[i]);
    return n;
  endfunction

  //////////////////////////////
  // sync word select
  //////////////////////////////

  always_comb
  begin
    case (access_sel)
      ACC_CAC:  sync_sel = syncword_cac;
      ACC_DAC:  sync_sel = syncword_dac;
      ACC_GIAC: sync_sel = syncword_giac;
      ACC_DIAC: sync_sel = syncword_diac;
      default:  sync_sel = syncword_cac;
    endcase
  end

  // ones where window and word agree
  assign agree = ~(window ^ sync_sel);

  //////////////////////////////
  // score and compare
  //////////////////////////////

  // stage 1, count taken on bit_p
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      score     <= '0;
      score_vld <= 1'b0;
    end
    else
    begin
      score_vld <= bit_p;
      if (bit_p)
        score <= count_ones(agree);
    end
  end

  assign hit = score_vld && (score >= {1'b0, correthreshold});

  // stage 2, pulse and slot capture
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      corre_sync_p <= 1'b0;
      sync_clk_hi  <= '0;
    end
    else
    begin
      corre_sync_p <= hit;
      if (hit)
        sync_clk_hi <= clk.parts.slot_hi;
    end
  end

endmodule

// ==== rtl/bt_baseband_top.sv ====
`timescale 1ns/1ps

module bt_baseband_top
  import bt_pkg::*;
(
  input  logic                 clk_6M,
  input  logic                 rstz,
  input  logic                 is_master,
  input  logic                 rxbit,
  input  logic [BT_CLK_W-1:0]  slave_offset,
  input  logic [1:0]           access_sel,
  input  logic [SYNC_W-1:0]    syncword_cac,
  input  logic [SYNC_W-1:0]    syncword_dac,
  input  logic [SYNC_W-1:0]    syncword_giac,
  input  logic [SYNC_W-1:0]    syncword_diac,
  input  logic [THRESH_W-1:0]  correthreshold,
  output logic [BT_CLK_W-1:0]  clkn,
  output logic [BT_CLK_W-1:0]  clk,
  output logic                 p_1us,
  output logic                 slot_p,
  output logic                 corre_sync_p,
  output logic [SLOT_HI_W-1:0] sync_clk_hi
);

  bt_clk_u           clkn_w;
  bt_clk_u           clk_w;
  logic [SYNC_W-1:0] window;
  logic              bit_p;

  assign clkn = clkn_w.raw;
  assign clk  = clk_w.raw;

  //////////////////////////////
  // clocks
  //////////////////////////////

  bt_timebase timebase_u (
    .clk_6M       (clk_6M      ),
    .rstz         (rstz        ),
    .is_master    (is_master   ),
    .slave_offset (slave_offset),
    .p_1us        (p_1us       ),
    .slot_p       (slot_p      ),
    .clkn         (clkn_w      ),
    .clk          (clk_w       )
  );

  //////////////////////////////
  // receive path
  //////////////////////////////

  bt_rx_window rx_window_u (
    .clk_6M (clk_6M),
    .rstz   (rstz  ),
    .rxbit  (rxbit ),
    .p_1us  (p_1us ),
    .window (window),
    .bit_p  (bit_p )
  );

  bt_sync_correlator correlator_u (
    .clk_6M         (clk_6M        ),
    .rstz           (rstz          ),
    .bit_p          (bit_p         ),
    .window         (window        ),
    .syncword_cac   (syncword_cac  ),
    .syncword_dac   (syncword_dac  ),
    .syncword_giac  (syncword_giac ),
    .syncword_diac  (syncword_diac ),
    .access_sel     (access_sel    ),
    .correthreshold (correthreshold),
    .clk            (clk_w         ),
    .corre_sync_p   (corre_sync_p  ),
    .sync_clk_hi    (sync_clk_hi   )
  );

endmodule

// ==== test/tb_checks.svh ====
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

//////////////////////////////
// check bookkeeping
//////////////////////////////

int error_count = 0;
int check_count = 0;

// compare one value, report a mismatch
task automatic check_value(input string name, input logic [63:0] got,
                           input logic [63:0] expected);
  check_count++;
  if (got !== expected)
  begin
    error_count++;
    $display("FAIL time=%0t %s got=%0h expected=%0h", $time, name, got, expected);
  end
endtask

// failures that are not a wrong value
task automatic note_error(input string msg);
  error_count++;
  $display("ERROR time=%0t %s", $time, msg);
endtask

// one closing line with the counts
task automatic print_counts();
  $display("checks=%0d errors=%0d", check_count, error_count);
endtask

`endif

// ==== test/tb_bt_top.sv ====
`timescale 1ns/1ps

module tb_bt_top
  import bt_pkg::*;
();

  localparam logic [31:0] SEED           = 32'h6d63_0532;
  localparam int          STROBE_TIMEOUT = 20;
  localparam int          CLKN_TIMEOUT   = 4000;
  localparam int          LEAD_FILL      = 70;
  localparam int          TAIL_FILL      = 8;
  localparam string       DATA_FILE      = "test/bt_testdata.txt";

  logic                 clk_6M;
  logic                 rstz;
  logic                 is_master;
  logic                 rxbit;
  logic [BT_CLK_W-1:0]  slave_offset;
  logic [1:0]           access_sel;
  logic [SYNC_W-1:0]    syncword_cac;
  logic [SYNC_W-1:0]    syncword_dac;
  logic [SYNC_W-1:0]    syncword_giac;
  logic [SYNC_W-1:0]    syncword_diac;
  logic [THRESH_W-1:0]  correthreshold;
  logic [BT_CLK_W-1:0]  clkn;
  logic [BT_CLK_W-1:0]  clk;
  logic                 p_1us;
  logic                 slot_p;
  logic                 corre_sync_p;
  logic [SLOT_HI_W-1:0] sync_clk_hi;

  // configuration the driver applies with every bit
  logic                cfg_master;
  logic [BT_CLK_W-1:0] cfg_offset;
  logic [1:0]          cfg_sel;
  logic [SYNC_W-1:0]   cfg_words [4];
  logic [THRESH_W-1:0] cfg_thr;

  // reference model state
  logic [SYNC_W-1:0] model_win = '0;
  logic              pend_rec = 1'b0;
  logic              exp_hit = 1'b0;
  int                exp_total = 0;
  int                dut_total = 0;
  int                rec_hits = 0;

  // monitor history
  logic [BT_CLK_W-1:0] prev_clk = '0;
  logic [BT_CLK_W-1:0] prev_clkn = '0;
  logic                bp_d1 = 1'b0;
  logic                bp_d2 = 1'b0;
  int                  since_tick = 0;
  logic                seen_tick = 1'b0;

  `include "tb_checks.svh"

  bt_baseband_top dut0 (
    .clk_6M         (clk_6M        ),
    .rstz           (rstz          ),
    .is_master      (is_master     ),
    .rxbit          (rxbit         ),
    .slave_offset   (slave_offset  ),
    .access_sel     (access_sel    ),
    .syncword_cac   (syncword_cac  ),
    .syncword_dac   (syncword_dac  ),
    .syncword_giac  (syncword_giac ),
    .syncword_diac  (syncword_diac ),
    .correthreshold (correthreshold),
    .clkn           (clkn          ),
    .clk            (clk           ),
    .p_1us          (p_1us         ),
    .slot_p         (slot_p        ),
    .corre_sync_p   (corre_sync_p  ),
    .sync_clk_hi    (sync_clk_hi   )
  );

  initial
  begin
    clk_6M = 1'b0;
    forever #5 clk_6M = ~clk_6M;
  end

  //////////////////////////////
  // helpers
  //////////////////////////////

  task automatic abort_run(input string msg);
    note_error(msg);
    print_counts();
    $display("Test failed");
    $finish;
  endtask

  // positions where both words hold the same bit
  function automatic int agreement(input logic [SYNC_W-1:0] a, input logic [SYNC_W-1:0] b);
    int n;
    n = 0;
    for (int i = 0; i < SYNC_W; i++)
      if (a[i] == b[i])
        n++;
    return n;
  endfunction

  task automatic apply_cfg();
    is_master      <= cfg_master;
    slave_offset   <= cfg_offset;
    access_sel     <= cfg_sel;
    syncword_cac   <= cfg_words[0];
    syncword_dac   <= cfg_words[1];
    syncword_giac  <= cfg_words[2];
    syncword_diac  <= cfg_words[3];
    correthreshold <= cfg_thr;
  endtask

  task automatic wait_strobe();
    int n;
    n = 0;
    @(negedge clk_6M);
    while (!p_1us)
    begin
      n++;
      if (n > STROBE_TIMEOUT)
        abort_run("no p_1us strobe seen within the timeout");
      @(negedge clk_6M);
    end
  endtask

  // the dut scores the previous window with the config applied here
  task automatic drive_bit(input logic b, input logic in_rec);
    int s;
    wait_strobe();
    @(posedge clk_6M);
    apply_cfg();
    s = agreement(model_win, cfg_words[cfg_sel]);
    exp_hit = (s >= int'(cfg_thr));
    if (exp_hit)
    begin
      exp_total++;
      if (pend_rec)
        rec_hits++;
    end
    rxbit     <= b;
    model_win = {model_win[SYNC_W-2:0], b};
    pend_rec  = in_rec;
  endtask

  task automatic wait_clkn_change();
    logic [BT_CLK_W-1:0] snap;
    int n;
    n = 0;
    @(negedge clk_6M);
    snap = clkn;
    @(negedge clk_6M);
    while (clkn == snap)
    begin
      n++;
      if (n > CLKN_TIMEOUT)
        abort_run("clkn did not advance within the timeout");
      @(negedge clk_6M);
    end
  endtask

  //////////////////////////////
  // clock checks
  //////////////////////////////

  task automatic check_strobe_period();
    int cnt;
    int last;
    cnt = 0;
    last = -1;
    // start at the first clocked cycle after reset release
    @(negedge clk_6M);
    for (int i = 0; i < 60; i++)
    begin
      @(negedge clk_6M);
      if (p_1us)
      begin
        if (last >= 0)
          check_value("p_1us spacing", 64'(i - last), 64'(CLKS_PER_US));
        cnt++;
        last = i;
      end
    end
    check_value("p_1us count", 64'(cnt), 64'd10);
  endtask

  task automatic check_piconet(input logic m, input logic [BT_CLK_W-1:0] off);
    logic [BT_CLK_W-1:0] expected;
    cfg_master = m;
    cfg_offset = off;
    @(posedge clk_6M);
    apply_cfg();
    repeat (2)
    begin
      wait_clkn_change();
      @(negedge clk_6M);
      expected = m ? clkn : clkn + off;
      check_value("clk", 64'(clk), 64'(expected));
    end
  endtask

  // continuous checks on clocks and sync pulses
  always @(negedge clk_6M)
  begin
    if (rstz)
    begin
      check_value("slot_p", 64'(slot_p),
                  64'((clk[1:0] == 2'b00) && (prev_clk[1:0] != 2'b00)));
      if (corre_sync_p)
      begin
        dut_total++;
        check_value("sync_clk_hi", 64'(sync_clk_hi), 64'(prev_clk[BT_CLK_W-1:2]));
      end
      // pulse due two cycles after bit_p when the model window hits
      check_value("corre_sync_p", 64'(corre_sync_p), 64'(bp_d2 && exp_hit));
      since_tick++;
      if (clkn != prev_clkn)
      begin
        check_value("clkn", 64'(clkn), 64'(prev_clkn + 28'd1));
        if (seen_tick)
          check_value("clkn period", 64'(since_tick), 64'(CLKS_PER_HALF_SLOT));
        seen_tick  = 1'b1;
        since_tick = 0;
      end
      prev_clk  = clk;
      prev_clkn = clkn;
      bp_d2     = bp_d1;
      bp_d1     = dut0.rx_window_u.bit_p;
    end
  end

  //////////////////////////////
  // records from the data file
  //////////////////////////////

  task automatic next_line(input int fd, output string line, output logic ok);
    string s;
    int r;
    ok = 1'b0;
    while (!ok)
    begin
      r = $fgets(s, fd);
      if (r == 0)
        break;
      if (s.len() > 1 && s.getc(0) != "#")
      begin
        line = s;
        ok = 1'b1;
      end
    end
  endtask

  task automatic run_records();
    int fd;
    int rec;
    int m;
    int sel;
    int thr;
    int nbits;
    int expc;
    logic ok;
    string line;
    logic [BT_CLK_W-1:0] off;
    logic [SYNC_W-1:0] w0, w1, w2, w3, stream;
    rec = 0;
    fd = $fopen(DATA_FILE, "r");
    if (fd == 0)
      abort_run("cannot open the test data file");
    next_line(fd, line, ok);
    while (ok)
    begin
      if ($sscanf(line, "%d %h %d %d %d %d", m, off, sel, thr, nbits, expc) != 6)
        abort_run("malformed config line in the test data file");
      next_line(fd, line, ok);
      if (!ok || $sscanf(line, "%h %h %h %h", w0, w1, w2, w3) != 4)
        abort_run("malformed sync word line in the test data file");
      next_line(fd, line, ok);
      if (!ok || $sscanf(line, "%h", stream) != 1)
        abort_run("malformed bit stream line in the test data file");
      if (nbits < 1 || nbits > SYNC_W)
        abort_run("bit count in the test data file is out of range");
      cfg_master   = 1'(m);
      cfg_offset   = off;
      cfg_sel      = 2'(sel);
      cfg_thr      = THRESH_W'(thr);
      cfg_words[0] = w0;
      cfg_words[1] = w1;
      cfg_words[2] = w2;
      cfg_words[3] = w3;
      rec_hits     = 0;
      repeat (LEAD_FILL)
        drive_bit(1'($urandom()), 1'b0);
      // msb goes out first
      for (int i = nbits - 1; i >= 0; i--)
        drive_bit(stream[i], 1'b1);
      repeat (TAIL_FILL)
        drive_bit(1'($urandom()), 1'b0);
      // let the last pulse drain, short of the next strobe
      repeat (4) @(negedge clk_6M);
      check_value($sformatf("record %0d sync pulses", rec), 64'(rec_hits), 64'(expc));
      check_value("corre_sync_p total", 64'(dut_total), 64'(exp_total));
      rec++;
      next_line(fd, line, ok);
    end
    $fclose(fd);
    if (rec == 0)
      note_error("the test data file holds no records");
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial
  begin
    void'($urandom(SEED));
    cfg_master = 1'b1;
    cfg_offset = '0;
    cfg_sel    = ACC_CAC;
    cfg_thr    = '1;
    for (int i = 0; i < 4; i++)
      cfg_words[i] = '1;
    rstz           = 1'b0;
    rxbit          = 1'b0;
    is_master      = cfg_master;
    slave_offset   = cfg_offset;
    access_sel     = cfg_sel;
    syncword_cac   = cfg_words[0];
    syncword_dac   = cfg_words[1];
    syncword_giac  = cfg_words[2];
    syncword_diac  = cfg_words[3];
    correthreshold = cfg_thr;
    repeat (4) @(posedge clk_6M);
    rstz <= 1'b1;

    check_strobe_period();
    check_piconet(1'b1, 28'h5a3c0e1);
    check_piconet(1'b0, 28'h0123456);
    check_piconet(1'b0, 28'hfffffff);
    check_piconet(1'b1, 28'h0000000);
    run_records();

    print_counts();
    if (error_count == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

// ==== test/bt_testdata.txt ====
# config: is_master slave_offset(hex) access_sel threshold bit_count expected_pulses
# then sync words cac dac giac diac (hex), then the bit stream (hex, msb sent first)
1 0000000 0 63 64 1
4e7a2d139bc506f8 b3159e60a7d42c8b 9e8b33ad5c4a0e71 1d6c52f08be3a794
4e7a2d139bc506f8
0 0123456 1 63 64 1
4e7a2d139bc506f8 b3159e60a7d42c8b 9e8b33ad5c4a0e71 1d6c52f08be3a794
b3159e60a7d42c8b
0 ffffff0 2 63 64 1
4e7a2d139bc506f8 b3159e60a7d42c8b 9e8b33ad5c4a0e71 1d6c52f08be3a794
9e8b33ad5c4a0e71
1 0000000 3 63 64 1
4e7a2d139bc506f8 b3159e60a7d42c8b 9e8b33ad5c4a0e71 1d6c52f08be3a794
1d6c52f08be3a794
# cac with three bits flipped
1 0000000 0 60 64 1
4e7a2d139bc506f8 b3159e60a7d42c8b 9e8b33ad5c4a0e71 1d6c52f08be3a794
4e7a2d139bc506ff
0 0200000 0 62 64 0
4e7a2d139bc506f8 b3159e60a7d42c8b 9e8b33ad5c4a0e71 1d6c52f08be3a794
4e7a2d139bc506ff
# dac sent while cac is selected
1 0000000 0 56 64 0
4e7a2d139bc506f8 b3159e60a7d42c8b 9e8b33ad5c4a0e71 1d6c52f08be3a794
b3159e60a7d42c8b
# giac with five bits flipped
0 7000001 2 58 64 1
4e7a2d139bc506f8 b3159e60a7d42c8b 9e8b33ad5c4a0e71 1d6c52f08be3a794
9e8b33ad5c4a0e6e
# diac with two flips, then with one flip
1 0000000 3 63 64 0
4e7a2d139bc506f8 b3159e60a7d42c8b 9e8b33ad5c4a0e71 1d6c52f08be3a794
1d6c52f08be3a797
1 0000000 3 63 64 1
4e7a2d139bc506f8 b3159e60a7d42c8b 9e8b33ad5c4a0e71 1d6c52f08be3a794
1d6c52f08be3a795

// ==== compile.f ====
+incdir+test
rtl/bt_pkg.sv
rtl/bt_timebase.sv
rtl/bt_rx_window.sv
rtl/bt_sync_correlator.sv
rtl/bt_baseband_top.sv
test/tb_bt_top.sv

// ==== Makefile ====
TOP := tb_bt_top

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f compile.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir
